// ==== Bender.yml ====
package:
  name: sample_stream

export_include_dirs:
  - logic

sources:
  - target: rtl
    files:
      - logic/stream_data_pkg.sv
      - logic/stream_ctrl_pkg.sv
      - logic/frame_tagger.sv
      - logic/stream_fifo.sv
      - logic/word_packer.sv
      - logic/sample_stream_top.sv
  - target: test
    files:
      - verif/sample_stream_props.sv
      - verif/sample_stream_tb.sv

// ==== logic/frame_tagger.sv ====
`timescale 1ns/10ps
`include "stream_cfg.svh"

module frame_tagger (
    input  logic                          clk_i,
    input  logic                          m_reset_ni,
    input  logic                          sample_valid_i,
    input  logic [`SAMPLE_WIDTH-1:0]      sample_data_i,
    output logic                          beat_valid_o,
    output stream_data_pkg::sample_beat_t beat_o
);

    import stream_ctrl_pkg::*;

    localparam int POS_W = $clog2(`FRAME_LEN);

    frame_pos_e       pos_state_q;
    logic [POS_W-1:0] pos_cnt_q;

    // The counter holds the index of the next sample in its frame.
    // The state moves to FP_END once the sample before the last one has passed
    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            pos_state_q <= FP_START;
            pos_cnt_q   <= '0;
        end else if (sample_valid_i) begin
            if (pos_state_q == FP_END) begin
                pos_state_q <= FP_START;
                pos_cnt_q   <= '0;
            end else begin
                pos_cnt_q <= pos_cnt_q + 1'b1;
                if (pos_cnt_q == POS_W'(`FRAME_LEN - 2)) begin
                    pos_state_q <= FP_END;
                end else begin
                    pos_state_q <= FP_BODY;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= sample_valid_i;
        end
    end

    // Payload follows the strobe, so the tagged beat lags the input by one cycle
    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            beat_o.data <= sample_data_i;
            beat_o.sof  <= (pos_state_q == FP_START);
            beat_o.last <= (pos_state_q == FP_END);
        end
    end

endmodule

// ==== logic/sample_stream_top.sv ====
`timescale 1ns/10ps
`include "stream_cfg.svh"

module sample_stream_top (
    input  logic                          clk_i,
    input  logic                          m_reset_ni,
    input  logic                          sample_valid_i,
    input  logic [`SAMPLE_WIDTH-1:0]      sample_data_i,
    output stream_data_pkg::packed_word_t word_o,
    output logic                          word_valid_o,
    input  logic                          word_ready_i,
    output stream_ctrl_pkg::fifo_status_t fifo_status_o
);

    import stream_data_pkg::*;

    sample_beat_t tag_beat;
    sample_beat_t fifo_beat;
    logic         tag_valid;
    logic         fifo_valid;
    logic         pack_ready;

    // Producer strobes have no back-pressure, so the tagger feeds the FIFO directly
    frame_tagger u_frame_tagger (
        .clk_i          (clk_i),
        .m_reset_ni     (m_reset_ni),
        .sample_valid_i (sample_valid_i),
        .sample_data_i  (sample_data_i),
        .beat_valid_o   (tag_valid),
        .beat_o         (tag_beat)
    );

    stream_fifo u_stream_fifo (
        .clk_i      (clk_i),
        .m_reset_ni (m_reset_ni),
        .wr_valid_i (tag_valid),
        .wr_beat_i  (tag_beat),
        .rd_valid_o (fifo_valid),
        .rd_beat_o  (fifo_beat),
        .rd_ready_i (pack_ready),
        .status_o   (fifo_status_o)
    );

    word_packer u_word_packer (
        .clk_i        (clk_i),
        .m_reset_ni   (m_reset_ni),
        .in_valid_i   (fifo_valid),
        .in_beat_i    (fifo_beat),
        .in_ready_o   (pack_ready),
        .word_o       (word_o),
        .word_valid_o (word_valid_o),
        .word_ready_i (word_ready_i)
    );

endmodule

// ==== logic/stream_cfg.svh ====
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// Bits per sample as delivered by the producer
`define SAMPLE_WIDTH 16

// Number of FIFO entries, must be a power of two
`define FIFO_DEPTH 8

// Samples per frame.
// Must be even so that every frame closes on a word boundary in the packer
`define FRAME_LEN 4

`endif

// ==== logic/stream_ctrl_pkg.sv ====
`include "stream_cfg.svh"

package stream_ctrl_pkg;

    // Address bits of the FIFO memory
    localparam int FIFO_PTR_W = $clog2(`FIFO_DEPTH);

    // Level has one extra bit since it also counts a beat parked in the output register
    typedef struct packed {
        logic [FIFO_PTR_W:0] level;
        logic                empty;
        logic                full;
        logic                overflow;
    } fifo_status_t;

    // Packer slot state
    typedef enum logic [1:0] {
        PK_EMPTY = 2'd0,
        PK_HALF  = 2'd1,
        PK_FULL  = 2'd2
    } packer_state_e;

    // Where the next incoming sample falls inside its frame
    typedef enum logic [1:0] {
        FP_START = 2'd0,
        FP_BODY  = 2'd1,
        FP_END   = 2'd2
    } frame_pos_e;

endpackage

// ==== logic/stream_data_pkg.sv ====
`include "stream_cfg.svh"

package stream_data_pkg;

    // One tagged sample on its way from the tagger through the FIFO.
    // The sof bit travels as the user bit and last closes the frame
    typedef struct packed {
        logic [`SAMPLE_WIDTH-1:0] data;
        logic                     sof;
        logic                     last;
    } sample_beat_t;

    // Output word made of two consecutive samples.
    // The first sample of the pair sits in the low half
    typedef struct packed {
        logic [2*`SAMPLE_WIDTH-1:0] data;
        logic                       sof;
        logic                       last;
    } packed_word_t;

endpackage

// ==== logic/stream_fifo.sv ====
`timescale 1ns/10ps
`include "stream_cfg.svh"

module stream_fifo (
    input  logic                          clk_i,
    input  logic                          m_reset_ni,
    input  logic                          wr_valid_i,
    input  stream_data_pkg::sample_beat_t wr_beat_i,
    output logic                          rd_valid_o,
    output stream_data_pkg::sample_beat_t rd_beat_o,
    input  logic                          rd_ready_i,
    output stream_ctrl_pkg::fifo_status_t status_o
);

    import stream_data_pkg::*;
    import stream_ctrl_pkg::*;

    sample_beat_t          mem [`FIFO_DEPTH];

    // Pointers carry one wrap bit above the address
    logic [FIFO_PTR_W:0]   wr_ptr_q;
    logic [FIFO_PTR_W:0]   rd_ptr_q;
    logic [FIFO_PTR_W-1:0] wr_addr;
    logic [FIFO_PTR_W-1:0] rd_addr;

    logic                  mem_empty;
    logic                  mem_full;
    logic                  wr_en;
    logic                  rd_en;
    logic                  out_held;
    logic                  overflow_q;

    assign wr_addr = wr_ptr_q[FIFO_PTR_W-1:0];
    assign rd_addr = rd_ptr_q[FIFO_PTR_W-1:0];

    // Same address with different wrap bits means the memory has wrapped onto itself
    assign mem_empty = (wr_ptr_q == rd_ptr_q);
    assign mem_full  = (wr_addr == rd_addr) && (wr_ptr_q[FIFO_PTR_W] != rd_ptr_q[FIFO_PTR_W]);

    // A write into a full memory is dropped so that stored beats stay intact
    assign wr_en = wr_valid_i && !mem_full;

    // The output register keeps its beat while the reader stalls
    assign out_held = rd_valid_o && !rd_ready_i;

    // Refill the output register when it is free or being emptied this cycle
    assign rd_en = !mem_empty && !out_held;

    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            wr_ptr_q <= '0;
        end else if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            rd_ptr_q   <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= !mem_empty || out_held;
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Output stage. A written entry shows up here one cycle after its write edge
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rd_beat_o <= mem[rd_addr];
        end
    end

    // Sticky until reset and records that at least one beat was lost
    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            overflow_q <= 1'b0;
        end else if (wr_valid_i && mem_full) begin
            overflow_q <= 1'b1;
        end
    end

    // Level counts the memory entries plus a beat parked in the output register
    assign status_o.level    = (wr_ptr_q - rd_ptr_q) + (FIFO_PTR_W + 1)'(out_held);
    // Empty only once the output register holds no beat either
    assign status_o.empty    = mem_empty && !rd_valid_o;
    assign status_o.full     = mem_full;
    assign status_o.overflow = overflow_q;

endmodule

// ==== logic/word_packer.sv ====
`timescale 1ns/10ps

module word_packer (
    input  logic                          clk_i,
    input  logic                          m_reset_ni,
    input  logic                          in_valid_i,
    input  stream_data_pkg::sample_beat_t in_beat_i,
    output logic                          in_ready_o,
    output stream_data_pkg::packed_word_t word_o,
    output logic                          word_valid_o,
    input  logic                          word_ready_i
);

    import stream_data_pkg::*;
    import stream_ctrl_pkg::*;

    packer_state_e state_q;
    packer_state_e state_d;
    sample_beat_t  first_q;
    logic          take;
    logic          word_xfer;

    // A full slot frees up in the same cycle its word leaves, so the
    // next first sample can be taken right away
    assign in_ready_o   = (state_q != PK_FULL) || word_ready_i;
    assign take         = in_valid_i && in_ready_o;
    assign word_valid_o = (state_q == PK_FULL);
    assign word_xfer    = word_valid_o && word_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            PK_EMPTY: begin
                if (take) begin
                    state_d = PK_HALF;
                end
            end
            PK_HALF: begin
                if (take) begin
                    state_d = PK_FULL;
                end
            end
            PK_FULL: begin
                if (word_xfer) begin
                    state_d = take ? PK_HALF : PK_EMPTY;
                end
            end
            default: begin
                state_d = PK_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            state_q <= PK_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // Any beat taken outside PK_HALF opens a new pair
    always_ff @(posedge clk_i) begin
        if (take && (state_q != PK_HALF)) begin
            first_q <= in_beat_i;
        end
    end

    // The word is only written on entry to PK_FULL and stays put while the consumer stalls
    always_ff @(posedge clk_i) begin
        if (take && (state_q == PK_HALF)) begin
            word_o.data <= {in_beat_i.data, first_q.data};
            word_o.sof  <= first_q.sof;
            word_o.last <= in_beat_i.last;
        end
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/stream_data_pkg.sv
logic/stream_ctrl_pkg.sv
logic/frame_tagger.sv
logic/stream_fifo.sv
logic/word_packer.sv
logic/sample_stream_top.sv
verif/sample_stream_props.sv
verif/sample_stream_tb.sv

// ==== verif/sample_stream_props.sv ====
`timescale 1ns/10ps

module sample_stream_props (
    input logic                          clk_i,
    input logic                          m_reset_ni,
    input stream_data_pkg::packed_word_t word_o,
    input logic                          word_valid_o,
    input logic                          word_ready_i,
    input stream_ctrl_pkg::fifo_status_t fifo_status_o
);

    int unsigned fail_count = 0;

    // A stalled word stays valid and unchanged until the consumer takes it
    word_hold: assert property (@(posedge clk_i) disable iff (!m_reset_ni)
        word_valid_o && !word_ready_i |=> word_valid_o && $stable(word_o))
    else begin
        fail_count++;
        $error("word_o changed or was withdrawn while the consumer stalled");
    end

    // The FIFO only fills up behind a word that the consumer is stalling
    full_while_stalled: assert property (@(posedge clk_i) disable iff (!m_reset_ni)
        fifo_status_o.full |-> word_valid_o && !fifo_status_o.empty)
    else begin
        fail_count++;
        $error("FIFO reports full without a stalled word or together with empty");
    end

    // Only a reset may clear the overflow flag
    overflow_sticky: assert property (@(posedge clk_i)
        m_reset_ni && fifo_status_o.overflow |=> fifo_status_o.overflow)
    else begin
        fail_count++;
        $error("FIFO overflow flag fell without a reset");
    end

endmodule

// ==== verif/sample_stream_tb.sv ====
`timescale 1ns/10ps
`include "stream_cfg.svh"

module sample_stream_tb;

    import stream_data_pkg::*;
    import stream_ctrl_pkg::*;

    localparam int PAT_MAX         = 64;
    localparam int RESET_CYCLES    = 16;
    localparam int WAIT_LIMIT      = 400;
    localparam int WORDS_PER_FRAME = `FRAME_LEN / 2;
    // With the consumer stalled the path holds the FIFO memory, its output
    // register and both halves of the word parked in the packer
    localparam int HOLD_SAMPLES    = `FIFO_DEPTH + 3;

    logic                     clk_i;
    logic                     m_reset_ni;
    logic                     sample_valid_i;
    logic [`SAMPLE_WIDTH-1:0] sample_data_i;
    packed_word_t             word_o;
    logic                     word_valid_o;
    logic                     word_ready_i;
    fifo_status_t             fifo_status_o;

    // Each entry holds kind, mode, gap and data as laid out in the pattern file
    logic [27:0]              pat_mem [PAT_MAX];
    packed_word_t             exp_q [$];
    logic [3:0]               stall_mode = 4'd0;
    logic [7:0]               lfsr_q = 8'd91;
    int                       sent_idx = 0;
    int                       words_seen = 0;
    int                       sec_sent = 0;
    logic [`SAMPLE_WIDTH-1:0] half_data;
    logic                     half_sof;
    logic                     have_half = 1'b0;

    sample_stream_top u_sample_stream_top (
        .clk_i          (clk_i),
        .m_reset_ni     (m_reset_ni),
        .sample_valid_i (sample_valid_i),
        .sample_data_i  (sample_data_i),
        .word_o         (word_o),
        .word_valid_o   (word_valid_o),
        .word_ready_i   (word_ready_i),
        .fifo_status_o  (fifo_status_o)
    );

    bind sample_stream_top sample_stream_props u_props (.*);

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // Galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("** Error %s: got 0x%0h, expected 0x%0h",
                                name, got, expected));
        end
    endtask

    // A failing bound assertion ends the run as soon as it fires
    always @(u_sample_stream_top.u_props.fail_count) begin
        if (u_sample_stream_top.u_props.fail_count != 0) begin
            abort_run("An assertion of the bound checker failed");
        end
    end

    // Reference model. A sample's place in its frame follows from how many
    // strobes were sent since reset, and samples pair up in sending order
    task automatic model_push(input logic [`SAMPLE_WIDTH-1:0] data);
        packed_word_t w;
        logic         sof;
        logic         last;
        sof  = (sent_idx % `FRAME_LEN) == 0;
        last = (sent_idx % `FRAME_LEN) == `FRAME_LEN - 1;
        if (have_half) begin
            w.data = {data, half_data};
            w.sof  = half_sof;
            w.last = last;
            exp_q.push_back(w);
            have_half = 1'b0;
        end else begin
            half_data = data;
            half_sof  = sof;
            have_half = 1'b1;
        end
        sent_idx++;
    endtask

    // Called at time zero or on a falling edge
    task automatic apply_reset();
        m_reset_ni     = 1'b0;
        sample_valid_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        exp_q.delete();
        sent_idx   = 0;
        have_half  = 1'b0;
        words_seen = 0;
        m_reset_ni = 1'b1;
    endtask

    task automatic check_reset_state();
        @(negedge clk_i);
        check_value("word_valid_o", word_valid_o, 1'b0);
        check_value("fifo_status_o.empty", fifo_status_o.empty, 1'b1);
        check_value("fifo_status_o.full", fifo_status_o.full, 1'b0);
        check_value("fifo_status_o.level", fifo_status_o.level, '0);
        check_value("fifo_status_o.overflow", fifo_status_o.overflow, 1'b0);
    endtask

    task automatic send_sample(input logic [3:0] gap, input logic [`SAMPLE_WIDTH-1:0] data);
        repeat (gap) begin
            @(negedge clk_i);
            sample_valid_i = 1'b0;
        end
        @(negedge clk_i);
        sample_valid_i = 1'b1;
        sample_data_i  = data;
        model_push(data);
        sec_sent++;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_run("Timed out waiting for the expected words to be delivered");
        end
    endtask

    task automatic wait_overflow();
        int n;
        n = 0;
        while (!fifo_status_o.overflow && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (!fifo_status_o.overflow) begin
            abort_run("Timed out waiting for the FIFO to report an overflow");
        end
    endtask

    task automatic wait_word_count(input int target);
        int n;
        n = 0;
        while (words_seen < target && n < WAIT_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (words_seen < target) begin
            abort_run("Timed out waiting for the held words after releasing the stall");
        end
    endtask

    task automatic start_section(input logic [3:0] mode);
        @(posedge clk_i);
        stall_mode = mode;
        sec_sent   = 0;
    endtask

    task automatic finish_section(input logic [3:0] mode);
        int target;
        @(negedge clk_i);
        sample_valid_i = 1'b0;
        if (mode != 4'd2) begin
            wait_drained();
            check_value("fifo_status_o.overflow", fifo_status_o.overflow, 1'b0);
            check_value("fifo_status_o.empty", fifo_status_o.empty, 1'b1);
        end else if (sec_sent <= HOLD_SAMPLES) begin
            abort_run("The overflow section sends too few samples to overfill the path");
        end else begin
            target = words_seen + HOLD_SAMPLES / 2;
            wait_overflow();
            // Give the last strobes time to pass the tagger
            repeat (2) @(negedge clk_i);
            check_value("fifo_status_o.full", fifo_status_o.full, 1'b1);
            check_value("fifo_status_o.overflow", fifo_status_o.overflow, 1'b1);
            check_value("fifo_status_o.level", fifo_status_o.level, `FIFO_DEPTH + 1);
            check_value("word_valid_o", word_valid_o, 1'b1);
            @(posedge clk_i);
            stall_mode = 4'd0;
            wait_word_count(target);
            repeat (10) @(negedge clk_i);
            check_value("words delivered", words_seen, target);
            check_value("fifo_status_o.overflow", fifo_status_o.overflow, 1'b1);
            apply_reset();
            check_reset_state();
        end
    endtask

    // Consumer side. Ready is driven on the falling edge, so a word seen
    // here with ready high is the one taken on the next rising edge
    initial begin : consumer
        packed_word_t exp;
        word_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            case (stall_mode)
                4'd0: word_ready_i = 1'b1;
                4'd1: begin
                    word_ready_i = lfsr_q[0];
                    lfsr_q       = lfsr_step(lfsr_q);
                end
                default: word_ready_i = 1'b0;
            endcase
            if (m_reset_ni && word_valid_o && word_ready_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("A word arrived that the model did not expect");
                end else begin
                    exp = exp_q.pop_front();
                    check_value("word_o", word_o, exp);
                    // Frame marks once more from the word count alone
                    check_value("word_o.sof", word_o.sof,
                                (words_seen % WORDS_PER_FRAME) == 0);
                    check_value("word_o.last", word_o.last,
                                (words_seen % WORDS_PER_FRAME) == WORDS_PER_FRAME - 1);
                    words_seen++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [27:0] entry;
        logic [3:0]  kind;
        logic [3:0]  cur_mode;
        logic        in_section;
        logic        done;
        int          idx;
        m_reset_ni     = 1'b0;
        sample_valid_i = 1'b0;
        sample_data_i  = '0;
        cur_mode       = 4'd0;
        in_section     = 1'b0;
        done           = 1'b0;
        idx            = 0;
        $readmemh("verif/stream_patterns.txt", pat_mem);
        apply_reset();
        check_reset_state();
        while (!done) begin
            if (idx >= PAT_MAX) begin
                abort_run("The pattern file has no end marker");
            end else if ($isunknown(pat_mem[idx])) begin
                abort_run($sformatf("Pattern entry %0d is missing or unreadable", idx));
            end else begin
                entry = pat_mem[idx];
                kind  = entry[27:24];
                if (kind == 4'h0) begin
                    send_sample(entry[19:16], entry[15:0]);
                end else if (kind == 4'h1 || kind == 4'hF) begin
                    if (in_section) begin
                        finish_section(cur_mode);
                    end
                    if (kind == 4'h1) begin
                        cur_mode   = entry[23:20];
                        in_section = 1'b1;
                        start_section(cur_mode);
                    end else begin
                        done = 1'b1;
                    end
                end else begin
                    abort_run($sformatf("Pattern entry %0d has an unknown kind", idx));
                end
                idx++;
            end
        end
        if (u_sample_stream_top.u_props.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d assertion failures",
                                u_sample_stream_top.u_props.fail_count));
        end
    end

endmodule

// ==== verif/stream_patterns.txt ====
// Each token is K_M_G_DDDD in hex. K=1 opens a section with stall mode M
// (0 ready always high, 1 LFSR stalls, 2 ready held low to force an overflow).
// K=0 is a sample sent after G idle cycles with data DDDD, K=F ends the stimulus.

// Ready always high, back to back samples
1_0_0_0000
0_0_0_1001 0_0_0_2302 0_0_0_3A03 0_0_0_4C04
0_0_0_5E05 0_0_0_6F06 0_0_0_7B07 0_0_0_8D08

// Random consumer stalls with gaps that keep the load low
1_1_0_0000
0_0_2_9111 0_0_1_A222 0_0_3_B333 0_0_1_C444
0_0_2_D555 0_0_1_E666 0_0_3_F777 0_0_1_0888
0_0_2_1999 0_0_1_2AAA 0_0_3_3BBB 0_0_2_4CCC

// Consumer stalled while more samples arrive than the path can hold
1_2_0_0000
0_0_0_5101 0_0_0_5202 0_0_0_5303 0_0_0_5404
0_0_0_5505 0_0_0_5606 0_0_0_5707 0_0_0_5808
0_0_0_5909 0_0_0_5A0A 0_0_0_5B0B 0_0_0_5C0C
0_0_0_5D0D 0_0_0_5E0E 0_0_0_5F0F 0_0_0_6010
F_0_0_0000
